/* dv/tb_board_top.sv */
/*
 * Board top testbench
 * Drives the host port, switches, button and GPIO pins and checks the
 * register map, pads, arbitration and reset behavior
 */
`timescale 1ns/1ps
`default_nettype none

module tb_board_top import board_pkg::*; ();

  localparam int RstHold   = 16;
  localparam int Debounce  = 4;
  localparam int Seed      = 50246;
  localparam int MaxCycles = 4000;  // Longest test path is well under 1500 cycles

  logic      clk_sys;
  logic      rst_n;
  logic      btn_n;
  pin_vec_t  usr_sw_n;
  pin_vec_t  usr_led;
  logic      led_bootok;
  wire [7:0] gpio;
  bus_req_t  host_req;
  logic      host_req_valid;
  logic      host_req_ready;
  bus_rsp_t  host_rsp;
  logic      host_rsp_valid;
  pin_vec_t  pin_en;              // Bits the testbench drives
  pin_vec_t  pin_val;
  int        err_cnt;
  int        mon_err_cnt;
  int        assert_err_cnt;
  int        check_cnt;
  int        acc_cnt;
  int        rsp_cnt;
  int        cycle_cnt;

  board_top #(
    .RstHoldCycles  (RstHold),
    .DebounceCycles (Debounce)
  ) uut (
    .clk_sys_i        (clk_sys),
    .rst_n_i          (rst_n),
    .btn_n_i          (btn_n),
    .usr_sw_n_i       (usr_sw_n),
    .usr_led_o        (usr_led),
    .led_bootok_o     (led_bootok),
    .gpio_io          (gpio),
    .host_req_i       (host_req),
    .host_req_valid_i (host_req_valid),
    .host_req_ready_o (host_req_ready),
    .host_rsp_o       (host_rsp),
    .host_rsp_valid_o (host_rsp_valid)
  );

  // Board side of the pads
  for (genvar i = 0; i < 8; i++) begin : g_pin
    assign gpio[i] = pin_en[i] ? pin_val[i] : 1'bz;
    pulldown (gpio[i]);
  end

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycle_cnt++;
    if (cycle_cnt == MaxCycles) begin
      $display("Run stopped after %0d cycles before the tests finished", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Handshake counts taken mid-cycle
  always @(negedge clk_sys) begin
    if (host_req_valid && host_req_ready) acc_cnt++;
    if (host_rsp_valid) begin
      rsp_cnt++;
      assert (rsp_cnt <= acc_cnt) else begin
        mon_err_cnt++;
        $display("External response arrived with no request outstanding");
      end
    end
  end

  // Immediate grant means the response follows on the next cycle
  assert property (@(posedge clk_sys) disable iff (!led_bootok)
    (host_req_valid && host_req_ready) |=> host_rsp_valid)
    else begin
      assert_err_cnt++;
      $display("External request accepted but no response one cycle later");
    end

  function automatic int error_total();
    return err_cnt + mon_err_cnt + assert_err_cnt;
  endfunction

  task automatic check_eq(input string name, input bus_data_t exp, input bus_data_t act);
    check_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_either(input string name, input bus_data_t exp_a,
                              input bus_data_t exp_b, input bus_data_t act);
    check_cnt++;
    assert (act === exp_a || act === exp_b) else begin
      err_cnt++;
      $display("ERROR %s: expected %h or %h, actual %h", name, exp_a, exp_b, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    check_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("%s", msg);
    end
  endtask

  task automatic test_done(input string name, input int err_before);
    $display("%s: %s, %0d errors", name, (error_total() == err_before) ? "ok" : "failed",
             error_total() - err_before);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #10;
  endtask

  task automatic sample_pins(output pin_vec_t p);
    @(negedge clk_sys);
    p = gpio;
    @(posedge clk_sys);
    #10;
  endtask

  // One transfer on the host port that returns 10 ns after an edge
  task automatic bus_access(input logic we, input reg_addr_t addr, input bus_data_t wdata,
                            output bus_data_t rdata);
    host_req       = '{we: we, addr: addr, wdata: wdata};
    host_req_valid = 1'b1;
    @(negedge clk_sys);
    while (!host_req_ready) @(negedge clk_sys);
    @(posedge clk_sys);
    #10;
    host_req_valid = 1'b0;
    @(negedge clk_sys);
    while (!host_rsp_valid) @(negedge clk_sys);
    rdata = host_rsp.rdata;
    @(posedge clk_sys);
    #10;
    check_true(acc_cnt == rsp_cnt, "External request left without exactly one response");
  endtask

  task automatic bus_write(input reg_addr_t addr, input bus_data_t wdata);
    bus_data_t rd;
    bus_access(1'b1, addr, wdata, rd);
    check_eq("write response", '0, rd);
  endtask

  task automatic bus_read(input reg_addr_t addr, output bus_data_t rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  // Polls the event counter until the switch host has posted
  task automatic wait_event_count(input int exp);
    bus_data_t rd;
    bus_read(ADDR_EVENT_COUNT, rd);
    while (rd < bus_data_t'(exp)) bus_read(ADDR_EVENT_COUNT, rd);
    check_eq("event count", bus_data_t'(exp), rd);
  endtask

  // Cycles from reset release until the boot LED lights
  task automatic measure_hold(input string name);
    int hold;
    hold = 0;
    @(negedge clk_sys);
    while (!led_bootok) begin
      hold++;
      @(negedge clk_sys);
    end
    @(posedge clk_sys);
    #10;
    check_true(hold >= RstHold,
               $sformatf("ERROR %s: expected at least %0d hold cycles, actual %0d",
                         name, RstHold, hold));
  endtask

  task automatic check_all_zero(input string name);
    bus_data_t rd;
    for (int a = 0; a < 6; a++) begin
      bus_read(reg_addr_t'(a), rd);
      check_eq($sformatf("%s reg %0d", name, a), '0, rd);
    end
  endtask

  initial begin
    int        e0;
    int        events;
    pin_vec_t  sw_val;
    pin_vec_t  sw_prev;
    pin_vec_t  v;
    pin_vec_t  out;
    pin_vec_t  oe;
    pin_vec_t  p;
    pin_vec_t  led_sh;
    pin_vec_t  out_sh;
    bus_data_t rd;

    void'($urandom(Seed));
    rst_n          = 1'b0;
    btn_n          = 1'b1;
    usr_sw_n       = '1;   // All switches off
    host_req       = '0;
    host_req_valid = 1'b0;
    pin_en         = '1;
    pin_val        = '0;
    events         = 0;
    sw_val         = '0;
    repeat (8) @(posedge clk_sys);
    #10;
    rst_n = 1'b1;

    e0 = error_total();
    measure_hold("reset release");
    check_eq("reset led", '0, bus_data_t'(usr_led));
    pin_val = '1;          // Clashes with any pad the DUT drives to its zero out value
    sample_pins(p);
    check_eq("reset pins released", bus_data_t'(pin_val), bus_data_t'(p));
    pin_val = '0;
    wait_cycles(3);
    check_all_zero("reset");
    test_done("reset release", e0);

    e0 = error_total();
    repeat (4) begin
      v = pin_vec_t'($urandom);
      bus_write(ADDR_LED, bus_data_t'(v));
      check_eq("led pins", bus_data_t'(v), bus_data_t'(usr_led));
      bus_read(ADDR_LED, rd);
      check_eq("led readback", bus_data_t'(v), rd);
    end
    repeat (4) begin
      out = pin_vec_t'($urandom);
      oe  = pin_vec_t'($urandom);
      bus_write(ADDR_GPIO_OUT, bus_data_t'(out));
      pin_en = pin_en & ~oe;    // Let go before the DUT takes the bits
      bus_write(ADDR_GPIO_OE, bus_data_t'(oe));
      pin_en  = ~oe;
      pin_val = pin_vec_t'($urandom);
      wait_cycles(3);
      sample_pins(p);
      check_eq("gpio pins", bus_data_t'((out & oe) | (pin_val & ~oe)), bus_data_t'(p));
      bus_read(ADDR_GPIO_IN, rd);
      check_eq("gpio input", bus_data_t'(p), rd);
      bus_read(ADDR_GPIO_OE, rd);
      check_eq("gpio oe readback", bus_data_t'(oe), rd);
    end
    bus_write(ADDR_GPIO_OE, '0);
    pin_en  = '1;
    pin_val = '0;
    test_done("led and gpio", e0);

    e0 = error_total();
    for (int a = 6; a < 8; a++) begin
      bus_write(reg_addr_t'(a), bus_data_t'($urandom) | 16'h0001);
      bus_read(reg_addr_t'(a), rd);
      check_eq($sformatf("unmapped reg %0d", a), '0, rd);
    end
    test_done("unmapped addresses", e0);

    e0 = error_total();
    sw_val   = pin_vec_t'($urandom) | 8'h01;
    usr_sw_n = ~sw_val;
    events++;
    wait_event_count(events);
    bus_read(ADDR_SW_EVENT, rd);
    check_eq("switch event", bus_data_t'(sw_val), rd);
    usr_sw_n = ~(sw_val ^ 8'h81);  // Short glitch
    wait_cycles(2);
    usr_sw_n = ~sw_val;
    wait_cycles(Debounce * 4);
    bus_read(ADDR_EVENT_COUNT, rd);
    check_eq("glitch count", bus_data_t'(events), rd);
    bus_read(ADDR_SW_EVENT, rd);
    check_eq("glitch event", bus_data_t'(sw_val), rd);
    test_done("switch events", e0);

    e0 = error_total();
    led_sh = pin_vec_t'($urandom);
    out_sh = pin_vec_t'($urandom);
    bus_write(ADDR_LED, bus_data_t'(led_sh));
    bus_write(ADDR_GPIO_OUT, bus_data_t'(out_sh));
    sw_prev = sw_val;
    for (int n = 0; n < 60; n++) begin
      if (n % 15 == 0) begin
        sw_prev  = sw_val;
        sw_val   = sw_val ^ (pin_vec_t'($urandom) | 8'h10);
        usr_sw_n = ~sw_val;
        events++;
      end
      case ($urandom % 4)
        0: begin
          led_sh = pin_vec_t'($urandom);
          bus_write(ADDR_LED, bus_data_t'(led_sh));
        end
        1: begin
          out_sh = pin_vec_t'($urandom);
          bus_write(ADDR_GPIO_OUT, bus_data_t'(out_sh));
        end
        2: begin
          bus_read(ADDR_LED, rd);
          check_eq("load led", bus_data_t'(led_sh), rd);
          bus_read(ADDR_GPIO_OUT, rd);
          check_eq("load gpio out", bus_data_t'(out_sh), rd);
        end
        default: begin
          bus_read(ADDR_SW_EVENT, rd);
          check_either("load switch event", bus_data_t'(sw_prev), bus_data_t'(sw_val), rd);
        end
      endcase
    end
    wait_event_count(events);
    bus_read(ADDR_SW_EVENT, rd);
    check_eq("load final event", bus_data_t'(sw_val), rd);
    test_done("arbitration under load", e0);

    e0 = error_total();
    if (sw_val != '0) begin
      events++;              // Turning the switches off is one more change
    end
    sw_val   = '0;           // Switches off so nothing is reported after reset
    usr_sw_n = '1;
    wait_event_count(events);
    bus_write(ADDR_LED, 16'h00a5);
    btn_n = 1'b0;
    wait_cycles(3);
    check_true(!led_bootok, "Boot LED stayed lit with the button pressed");
    check_eq("button led", '0, bus_data_t'(usr_led));
    btn_n = 1'b1;
    measure_hold("button reset");
    check_all_zero("button");
    test_done("button reset", e0);

    $display("Checks %0d, errors %0d", check_cnt, error_total());
    if (error_total() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_board_top \
  -f sim.f \
  -o tb_board_top

./obj_dir/tb_board_top | tee sim.log

# Pass only when the testbench printed the pass line
grep -q "^TEST PASS$" sim.log

/* sim.f */
source/board_pkg.sv
source/rst_ctrl.sv
source/sw_event_host.sv
source/bus_arbiter.sv
source/gpio_regs.sv
source/board_system.sv
source/board_top.sv
dv/tb_board_top.sv

/* source/board_pkg.sv */
/*
 * Board subsystem shared definitions
 * Bus request/response structs, register map and pin-bank types
 */
`default_nettype none

package board_pkg;

  // Bus data and register index widths
  typedef logic [15:0] bus_data_t;
  typedef logic [2:0]  reg_addr_t;

  // One bank of eight board pins
  typedef logic [7:0] pin_vec_t;

  typedef struct packed {
    logic      we;     // 1 = write
    reg_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    bus_data_t rdata;  // Zero for write responses
  } bus_rsp_t;

  // Register map
  localparam reg_addr_t ADDR_LED         = 3'd0;
  localparam reg_addr_t ADDR_GPIO_OUT    = 3'd1;
  localparam reg_addr_t ADDR_GPIO_OE     = 3'd2;
  localparam reg_addr_t ADDR_GPIO_IN     = 3'd3;  // Read only
  localparam reg_addr_t ADDR_SW_EVENT    = 3'd4;
  localparam reg_addr_t ADDR_EVENT_COUNT = 3'd5;

  // Arbiter grant owner
  typedef enum logic {
    GNT_EXT = 1'b0,
    GNT_SW  = 1'b1
  } host_sel_t;

endpackage

`default_nettype wire

/* source/board_system.sv */
/*
 * Board system
 * Switch event host and external host sharing the GPIO register block
 */
`timescale 1ns/1ps
`default_nettype none

module board_system import board_pkg::*; #(
  parameter int unsigned DebounceCycles = 1000
) (
  input  logic     clk_sys_i,
  input  logic     rst_n_i,
  input  pin_vec_t sw_i,

  // External host port
  input  bus_req_t ext_req_i,
  input  logic     ext_req_valid_i,
  output logic     ext_req_ready_o,
  output bus_rsp_t ext_rsp_o,
  output logic     ext_rsp_valid_o,

  output pin_vec_t led_o,
  output pin_vec_t gpio_out_o,
  output pin_vec_t gpio_oe_o,
  input  pin_vec_t gpio_in_i
);

  bus_req_t sw_req;
  logic     sw_req_valid;
  logic     sw_req_ready;
  logic     sw_rsp_valid;
  bus_req_t tgt_req;
  logic     tgt_req_valid;
  bus_rsp_t tgt_rsp;
  logic     tgt_rsp_valid;

  sw_event_host #(
    .DebounceCycles (DebounceCycles)
  ) u_sw_event_host (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .sw_i        (sw_i),
    .req_o       (sw_req),
    .req_valid_o (sw_req_valid),
    .req_ready_i (sw_req_ready),
    .rsp_valid_i (sw_rsp_valid)
  );

  bus_arbiter u_bus_arbiter (
    .clk_sys_i       (clk_sys_i),
    .rst_n_i         (rst_n_i),
    .ext_req_i       (ext_req_i),
    .ext_req_valid_i (ext_req_valid_i),
    .ext_req_ready_o (ext_req_ready_o),
    .ext_rsp_o       (ext_rsp_o),
    .ext_rsp_valid_o (ext_rsp_valid_o),
    .sw_req_i        (sw_req),
    .sw_req_valid_i  (sw_req_valid),
    .sw_req_ready_o  (sw_req_ready),
    .sw_rsp_o        (),              // Switch host only writes
    .sw_rsp_valid_o  (sw_rsp_valid),
    .tgt_req_o       (tgt_req),
    .tgt_req_valid_o (tgt_req_valid),
    .tgt_rsp_i       (tgt_rsp),
    .tgt_rsp_valid_i (tgt_rsp_valid)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .req_i       (tgt_req),
    .req_valid_i (tgt_req_valid),
    .rsp_o       (tgt_rsp),
    .rsp_valid_o (tgt_rsp_valid),
    .led_o       (led_o),
    .gpio_out_o  (gpio_out_o),
    .gpio_oe_o   (gpio_oe_o),
    .gpio_in_i   (gpio_in_i)
  );

endmodule

`default_nettype wire

/* source/board_top.sv */
/*
 * Board top level
 * Switch and button inversion, tri-state GPIO pads, boot LED and reset control
 */
`timescale 1ns/1ps
`default_nettype none

module board_top import board_pkg::*; #(
  parameter int unsigned RstHoldCycles  = 16,
  parameter int unsigned DebounceCycles = 1000
) (
  input  logic     clk_sys_i,
  input  logic     rst_n_i,
  input  logic     btn_n_i,        // Reset button that pulls low when pressed
  input  pin_vec_t usr_sw_n_i,     // User switches that pull low when on

  output pin_vec_t usr_led_o,
  output logic     led_bootok_o,
  inout  wire [7:0] gpio_io,

  // External host port
  input  bus_req_t host_req_i,
  input  logic     host_req_valid_i,
  output logic     host_req_ready_o,
  output bus_rsp_t host_rsp_o,
  output logic     host_rsp_valid_o
);

  logic     rst_sys_n;
  logic     rst_btn;
  pin_vec_t usr_sw;
  pin_vec_t gpio_out;
  pin_vec_t gpio_oe;
  pin_vec_t gpio_in;

  // Switches read 1 when on
  assign usr_sw  = ~usr_sw_n_i;
  assign rst_btn = ~btn_n_i;

  assign led_bootok_o = rst_sys_n;  // Lit once the system is out of reset

  // Released pins float to the board
  for (genvar i = 0; i < 8; i++) begin : g_gpio_pad
    assign gpio_io[i] = gpio_oe[i] ? gpio_out[i] : 1'bz;
  end

  assign gpio_in = gpio_io;  // Driven pins read back their own value

  rst_ctrl #(
    .RstHoldCycles (RstHoldCycles)
  ) u_rst_ctrl (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .rst_btn_i   (rst_btn),
    .rst_sys_n_o (rst_sys_n)
  );

  board_system #(
    .DebounceCycles (DebounceCycles)
  ) u_board_system (
    .clk_sys_i       (clk_sys_i),
    .rst_n_i         (rst_sys_n),
    .sw_i            (usr_sw),
    .ext_req_i       (host_req_i),
    .ext_req_valid_i (host_req_valid_i),
    .ext_req_ready_o (host_req_ready_o),
    .ext_rsp_o       (host_rsp_o),
    .ext_rsp_valid_o (host_rsp_valid_o),
    .led_o           (usr_led_o),
    .gpio_out_o      (gpio_out),
    .gpio_oe_o       (gpio_oe),
    .gpio_in_i       (gpio_in)
  );

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
/*
 * Two-host bus arbiter
 * Round-robin grant to one register target with one transaction outstanding
 * and the response steered back to the issuing host
 */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import board_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_n_i,

  // External host
  input  bus_req_t ext_req_i,
  input  logic     ext_req_valid_i,
  output logic     ext_req_ready_o,
  output bus_rsp_t ext_rsp_o,
  output logic     ext_rsp_valid_o,

  // Switch event host
  input  bus_req_t sw_req_i,
  input  logic     sw_req_valid_i,
  output logic     sw_req_ready_o,
  output bus_rsp_t sw_rsp_o,
  output logic     sw_rsp_valid_o,

  // Always-ready register target
  output bus_req_t tgt_req_o,
  output logic     tgt_req_valid_o,
  input  bus_rsp_t tgt_rsp_i,
  input  logic     tgt_rsp_valid_i
);

  logic      busy_q;      // Request outstanding at the target
  host_sel_t owner_q;     // Host waiting for the response
  host_sel_t last_q;      // Host served most recently
  host_sel_t gnt;
  logic      pick_sw;

  // Switch host wins if alone, or on a tie when the external host went last
  assign pick_sw = sw_req_valid_i && (!ext_req_valid_i || (last_q == GNT_EXT));
  assign gnt     = pick_sw ? GNT_SW : GNT_EXT;

  assign tgt_req_valid_o = !busy_q && (ext_req_valid_i || sw_req_valid_i);
  assign tgt_req_o       = pick_sw ? sw_req_i : ext_req_i;
  assign ext_req_ready_o = !busy_q && (gnt == GNT_EXT);
  assign sw_req_ready_o  = !busy_q && (gnt == GNT_SW);

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= GNT_EXT;
      last_q  <= GNT_SW;    // External host first on a tie
    end else if (tgt_req_valid_o) begin
      busy_q  <= 1'b1;
      owner_q <= gnt;
      last_q  <= gnt;
    end else if (busy_q && tgt_rsp_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  // Data goes to both hosts and valid only to the owner
  assign ext_rsp_o       = tgt_rsp_i;
  assign sw_rsp_o        = tgt_rsp_i;
  assign ext_rsp_valid_o = busy_q && tgt_rsp_valid_i && (owner_q == GNT_EXT);
  assign sw_rsp_valid_o  = busy_q && tgt_rsp_valid_i && (owner_q == GNT_SW);

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
/*
 * GPIO register block
 * LED, GPIO out/enable, GPIO input readback, switch event and event count
 * registers with a response one cycle after each request
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import board_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output bus_rsp_t rsp_o,
  output logic     rsp_valid_o,
  output pin_vec_t led_o,
  output pin_vec_t gpio_out_o,
  output pin_vec_t gpio_oe_o,
  input  pin_vec_t gpio_in_i
);

  pin_vec_t  led_q;
  pin_vec_t  gpio_out_q;
  pin_vec_t  gpio_oe_q;
  pin_vec_t  sw_event_q;
  bus_data_t event_cnt_q;
  pin_vec_t  gpio_meta;
  pin_vec_t  gpio_sync;
  bus_data_t rd_mux;
  bus_data_t rdata_q;
  logic      rsp_valid_q;

  // Input pin synchroniser
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_in_i;
      gpio_sync <= gpio_meta;
    end
  end

  always_comb begin
    case (req_i.addr)
      ADDR_LED:         rd_mux = {8'h00, led_q};
      ADDR_GPIO_OUT:    rd_mux = {8'h00, gpio_out_q};
      ADDR_GPIO_OE:     rd_mux = {8'h00, gpio_oe_q};
      ADDR_GPIO_IN:     rd_mux = {8'h00, gpio_sync};
      ADDR_SW_EVENT:    rd_mux = {8'h00, sw_event_q};
      ADDR_EVENT_COUNT: rd_mux = event_cnt_q;
      default:          rd_mux = '0;  // Unmapped
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      led_q       <= '0;
      gpio_out_q  <= '0;
      gpio_oe_q   <= '0;
      sw_event_q  <= '0;
      event_cnt_q <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      if (req_valid_i && req_i.we) begin
        case (req_i.addr)
          ADDR_LED:      led_q      <= req_i.wdata[7:0];
          ADDR_GPIO_OUT: gpio_out_q <= req_i.wdata[7:0];
          ADDR_GPIO_OE:  gpio_oe_q  <= req_i.wdata[7:0];
          ADDR_SW_EVENT: begin
            sw_event_q  <= req_i.wdata[7:0];
            event_cnt_q <= event_cnt_q + 1'b1;  // Count every event write
          end
          default: ;  // Read only or unmapped
        endcase
      end
    end
  end

  // Read data captured with the request and zeroed for writes
  always_ff @(posedge clk_sys_i) begin
    if (req_valid_i) begin
      rdata_q <= req_i.we ? '0 : rd_mux;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_valid_o = rsp_valid_q;
  assign led_o       = led_q;
  assign gpio_out_o  = gpio_out_q;
  assign gpio_oe_o   = gpio_oe_q;

endmodule

`default_nettype wire

/* source/rst_ctrl.sv */
/*
 * System reset controller
 * Holds the system reset low for a fixed count after board reset or button release
 */
`timescale 1ns/1ps
`default_nettype none

module rst_ctrl #(
  parameter int unsigned RstHoldCycles = 16
) (
  input  logic clk_sys_i,
  input  logic rst_n_i,
  input  logic rst_btn_i,    // Active high
  output logic rst_sys_n_o
);

  localparam int CntW = $clog2(RstHoldCycles + 1);

  logic [CntW-1:0] hold_cnt;
  logic            hold_last;

  // Last count value before release
  assign hold_last = (hold_cnt == CntW'(RstHoldCycles - 1));

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i || rst_btn_i) begin
      // Either source restarts the hold
      hold_cnt    <= '0;
      rst_sys_n_o <= 1'b0;
    end else if (!rst_sys_n_o) begin
      hold_cnt <= hold_cnt + 1'b1;
      if (hold_last) begin
        rst_sys_n_o <= 1'b1;  // Release after RstHoldCycles clean cycles
      end
    end
  end

endmodule

`default_nettype wire

/* source/sw_event_host.sv */
/*
 * Switch event bus host
 * Synchronises and debounces the user switches, then posts each stable change
 * as a write to the switch event register
 */
`timescale 1ns/1ps
`default_nettype none

module sw_event_host import board_pkg::*; #(
  parameter int unsigned DebounceCycles = 1000
) (
  input  logic     clk_sys_i,
  input  logic     rst_n_i,
  input  pin_vec_t sw_i,          // Active high
  output bus_req_t req_o,
  output logic     req_valid_o,
  input  logic     req_ready_i,
  input  logic     rsp_valid_i
);

  localparam int DbW = $clog2(DebounceCycles + 1);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RSP
  } state_e;

  state_e         state_q;
  pin_vec_t       sw_meta;
  pin_vec_t       sw_sync;
  pin_vec_t       sw_cand;        // Value currently being timed
  pin_vec_t       sw_last;        // Last value reported over the bus
  logic [DbW-1:0] stable_cnt;
  logic           stable;

  assign stable = (stable_cnt == DbW'(DebounceCycles));

  // Two-flop synchroniser and stability counter
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      sw_meta    <= '0;
      sw_sync    <= '0;
      sw_cand    <= '0;
      stable_cnt <= '0;
    end else begin
      sw_meta <= sw_i;
      sw_sync <= sw_meta;
      if (sw_sync != sw_cand) begin
        sw_cand    <= sw_sync;  // Restart timing on any change
        stable_cnt <= '0;
      end else if (!stable) begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

  // Report FSM with one write in flight at a time
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      sw_last <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (stable && (sw_cand != sw_last)) begin
            sw_last <= sw_cand;
            state_q <= REQ;
          end
        end
        REQ:      if (req_ready_i) state_q <= WAIT_RSP;
        WAIT_RSP: if (rsp_valid_i) state_q <= IDLE;
        default:  state_q <= IDLE;
      endcase
    end
  end

  // Payload held stable from sw_last while waiting for ready
  assign req_o.we    = 1'b1;
  assign req_o.addr  = ADDR_SW_EVENT;
  assign req_o.wdata = {8'h00, sw_last};
  assign req_valid_o = (state_q == REQ);

endmodule

`default_nettype wire
